/* include/ecc_params.svh */
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// bus sizes
`define ECC_AMBA_WORD           32
`define ECC_ADDR_WIDTH          20

// codeword limits, 32 bit word has 26 info and 6 parity bits
`define ECC_DATA_WIDTH          32
`define ECC_MAX_PARITY          6
`define ECC_MAX_INFO            26

// register byte offsets
`define ECC_ADDR_CTRL           20'h00000
`define ECC_ADDR_DATA_IN        20'h00004
`define ECC_ADDR_CW_WIDTH       20'h00008
`define ECC_ADDR_NOISE          20'h0000c

`endif

/* src/ecc_pkg.sv */
`include "ecc_params.svh"

package ecc_pkg;

        typedef enum logic [1:0] {
                OP_ENCODE       = 2'd0,
                OP_DECODE       = 2'd1,
                OP_FULL_CHANNEL = 2'd2   // 3 falls back to encode
        } ecc_op_t;

        typedef enum logic [1:0] {
                W8  = 2'd0,
                W16 = 2'd1,
                W32 = 2'd2               // 3 falls back to W32
        } ecc_width_t;

        typedef enum logic [1:0] {
                S_IDLE,
                S_WAIT1,
                S_WAIT2,
                S_DONE
        } ecc_state_t;

        // index code of info bit idx: idx-th non power of two from 3 up
        function automatic logic [`ECC_MAX_PARITY-1:0] ecc_info_code(input int idx);
                int cnt;
                logic [`ECC_MAX_PARITY-1:0] code;
                cnt = 0;
                code = '0;
                for (int v = 3; v < 64; v++) begin
                        if ((v & (v - 1)) != 0) begin
                                if (cnt == idx)
                                        code = v[`ECC_MAX_PARITY-1:0];
                                cnt++;
                        end
                end
                return code;
        endfunction

        function automatic logic [`ECC_MAX_INFO-1:0] ecc_info_mask(input ecc_width_t w);
                case (w)
                        W8:      return {{(`ECC_MAX_INFO-4){1'b0}}, 4'hf};
                        W16:     return {{(`ECC_MAX_INFO-11){1'b0}}, 11'h7ff};
                        default: return '1;
                endcase
        endfunction

        // parity bits 0..p-2, overall bit handled by the caller
        function automatic logic [`ECC_MAX_PARITY-2:0] ecc_parity(
                input logic [`ECC_MAX_INFO-1:0] info);
                logic [`ECC_MAX_PARITY-2:0] par;
                logic [`ECC_MAX_PARITY-1:0] code;
                par = '0;
                for (int j = 0; j < `ECC_MAX_INFO; j++) begin
                        code = ecc_info_code(j);
                        par ^= code[`ECC_MAX_PARITY-2:0] & {(`ECC_MAX_PARITY-1){info[j]}};
                end
                return par;
        endfunction

endpackage

/* src/ecc_apb_regs.sv */
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_apb_regs
        import ecc_pkg::*;
(
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            psel,
        input  logic                            penable,
        input  logic                            pwrite,
        input  logic [`ECC_ADDR_WIDTH-1:0]      paddr,
        input  logic [`ECC_AMBA_WORD-1:0]       pwdata,
        output logic [`ECC_AMBA_WORD-1:0]       prdata,
        output ecc_op_t                         ctrl,
        output logic [`ECC_AMBA_WORD-1:0]       data_in,
        output ecc_width_t                      cw_width,
        output logic [`ECC_AMBA_WORD-1:0]       noise,
        output logic                            start,
        input  logic                            busy
);

        logic [`ECC_AMBA_WORD-1:0] ctrl_reg;
        logic [`ECC_AMBA_WORD-1:0] cw_reg;
        logic                      wr_en;

        assign wr_en = psel & penable & pwrite;   // access phase write

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        ctrl_reg <= '0;
                        data_in  <= '0;
                        cw_reg   <= '0;
                        noise    <= '0;
                        start    <= 1'b0;
                end else begin
                        start <= 1'b0;
                        if (wr_en) begin
                                case (paddr)
                                        `ECC_ADDR_CTRL: begin
                                                ctrl_reg <= pwdata;
                                                start    <= ~busy;   // dropped while running
                                        end
                                        `ECC_ADDR_DATA_IN:  data_in <= pwdata;
                                        `ECC_ADDR_CW_WIDTH: cw_reg  <= pwdata;
                                        `ECC_ADDR_NOISE:    noise   <= pwdata;
                                        default: ;
                                endcase
                        end
                end
        end

        // read back
        always_comb begin
                prdata = '0;
                if (psel && !pwrite) begin
                        case (paddr)
                                `ECC_ADDR_CTRL:     prdata = ctrl_reg;
                                `ECC_ADDR_DATA_IN:  prdata = data_in;
                                `ECC_ADDR_CW_WIDTH: prdata = cw_reg;
                                `ECC_ADDR_NOISE:    prdata = noise;
                                default:            prdata = '0;
                        endcase
                end
        end

        assign ctrl     = ecc_op_t'(ctrl_reg[1:0]);
        assign cw_width = ecc_width_t'(cw_reg[1:0]);

endmodule

/* src/ecc_encoder.sv */
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_encoder
        import ecc_pkg::*;
(
        input  logic                            clk,
        input  logic                            rst,
        input  logic [`ECC_MAX_INFO-1:0]        data_in,
        input  ecc_width_t                      cw_width,
        output logic [`ECC_DATA_WIDTH-1:0]      enc_word
);

        logic [`ECC_MAX_INFO-1:0]       info;
        logic [`ECC_MAX_PARITY-2:0]     par;
        logic [`ECC_DATA_WIDTH-1:0]     cw_next;

        assign info = data_in & ecc_info_mask(cw_width);   // drop bits above k
        assign par  = ecc_parity(info);

        // info low, parity above, overall parity on top
        always_comb begin
                case (cw_width)
                        W8: begin
                                cw_next = {24'd0, ^{par[2:0], info[3:0]},
                                           par[2:0], info[3:0]};
                        end
                        W16: begin
                                cw_next = {16'd0, ^{par[3:0], info[10:0]},
                                           par[3:0], info[10:0]};
                        end
                        default: begin
                                cw_next = {^{par[4:0], info[25:0]},
                                           par[4:0], info[25:0]};
                        end
                endcase
        end

        always_ff @(posedge clk or negedge rst) begin
                if (!rst)
                        enc_word <= '0;
                else
                        enc_word <= cw_next;
        end

endmodule

/* src/ecc_decoder.sv */
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_decoder
        import ecc_pkg::*;
(
        input  logic                            clk,
        input  logic                            rst,
        input  logic [`ECC_DATA_WIDTH-1:0]      dec_in,
        input  ecc_width_t                      cw_width,
        output logic [`ECC_DATA_WIDTH-1:0]      dec_data,
        output logic [1:0]                      dec_errors
);

        logic [`ECC_MAX_INFO-1:0]       rx_info;
        logic [`ECC_MAX_PARITY-2:0]     rx_par;
        logic                           overall;
        logic [`ECC_MAX_PARITY-2:0]     syndrome;
        logic [`ECC_MAX_INFO-1:0]       fixed;
        logic [`ECC_MAX_INFO-1:0]       data_next;
        logic [1:0]                     errors_next;

        // split the received word, bits at n and above ignored
        always_comb begin
                case (cw_width)
                        W8: begin
                                rx_info = {{(`ECC_MAX_INFO-4){1'b0}}, dec_in[3:0]};
                                rx_par  = {2'b00, dec_in[6:4]};
                                overall = ^dec_in[7:0];
                        end
                        W16: begin
                                rx_info = {{(`ECC_MAX_INFO-11){1'b0}}, dec_in[10:0]};
                                rx_par  = {1'b0, dec_in[14:11]};
                                overall = ^dec_in[15:0];
                        end
                        default: begin
                                rx_info = dec_in[25:0];
                                rx_par  = dec_in[30:26];
                                overall = ^dec_in;
                        end
                endcase
        end

        assign syndrome = ecc_parity(rx_info) ^ rx_par;

        // flip the info bit whose code matches the syndrome
        always_comb begin : correct
                logic [`ECC_MAX_PARITY-1:0] code;
                fixed = rx_info;
                for (int j = 0; j < `ECC_MAX_INFO; j++) begin
                        code = ecc_info_code(j);
                        if (syndrome == code[`ECC_MAX_PARITY-2:0])
                                fixed[j] = ~fixed[j];
                end
        end

        always_comb begin
                if (overall) begin
                        data_next   = fixed;   // single error, parity bit hits land here too
                        errors_next = 2'd1;
                end else if (syndrome != '0) begin
                        data_next   = rx_info;   // double, pass through
                        errors_next = 2'd2;
                end else begin
                        data_next   = rx_info;
                        errors_next = 2'd0;
                end
        end

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        dec_data   <= '0;
                        dec_errors <= 2'd0;
                end else begin
                        dec_data   <= {{(`ECC_DATA_WIDTH-`ECC_MAX_INFO){1'b0}}, data_next};
                        dec_errors <= errors_next;
                end
        end

endmodule

/* src/ecc_channel_ctrl.sv */
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_channel_ctrl
        import ecc_pkg::*;
(
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            start,
        input  ecc_op_t                         ctrl,
        input  logic [`ECC_AMBA_WORD-1:0]       data_in,
        input  logic [`ECC_AMBA_WORD-1:0]       noise,
        input  logic [`ECC_DATA_WIDTH-1:0]      enc_word,
        input  logic [`ECC_DATA_WIDTH-1:0]      dec_data,
        input  logic [1:0]                      dec_errors,
        output logic [`ECC_DATA_WIDTH-1:0]      dec_in,
        output logic                            busy,
        output logic [`ECC_DATA_WIDTH-1:0]      data_out,
        output logic                            operation_done,
        output logic [1:0]                      num_of_errors
);

        ecc_state_t     state;
        logic           full;
        logic           enc_mode;
        logic           finish;

        assign full     = (ctrl == OP_FULL_CHANNEL);
        assign enc_mode = (ctrl != OP_DECODE) && !full;   // value 3 lands here

        // decoder source, noisy codeword unless decode only
        assign dec_in = (ctrl == OP_DECODE) ? data_in : (enc_word ^ noise);

        assign busy   = (state != S_IDLE);
        assign finish = ((state == S_WAIT1) && !full) || (state == S_WAIT2);

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        state <= S_IDLE;
                end else begin
                        case (state)
                                S_IDLE:  if (start) state <= S_WAIT1;
                                S_WAIT1: state <= full ? S_WAIT2 : S_DONE;
                                S_WAIT2: state <= S_DONE;
                                default: state <= S_IDLE;
                        endcase
                end
        end

        // results held until the next run
        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        operation_done <= 1'b0;
                        data_out       <= '0;
                        num_of_errors  <= 2'd0;
                end else begin
                        operation_done <= finish;
                        if (finish) begin
                                data_out      <= enc_mode ? enc_word : dec_data;
                                num_of_errors <= enc_mode ? 2'd0 : dec_errors;
                        end
                end
        end

endmodule

/* src/ecc_enc_dec.sv */
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_enc_dec
        import ecc_pkg::*;
(
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            psel,
        input  logic                            penable,
        input  logic                            pwrite,
        input  logic [`ECC_ADDR_WIDTH-1:0]      paddr,
        input  logic [`ECC_AMBA_WORD-1:0]       pwdata,
        output logic [`ECC_AMBA_WORD-1:0]       prdata,
        output logic [`ECC_DATA_WIDTH-1:0]      data_out,
        output logic                            operation_done,
        output logic [1:0]                      num_of_errors
);

        ecc_op_t                        ctrl;
        ecc_width_t                     cw_width;
        logic [`ECC_AMBA_WORD-1:0]      data_in;
        logic [`ECC_AMBA_WORD-1:0]      noise;
        logic                           start;
        logic                           busy;
        logic [`ECC_DATA_WIDTH-1:0]     enc_word;
        logic [`ECC_DATA_WIDTH-1:0]     dec_in;
        logic [`ECC_DATA_WIDTH-1:0]     dec_data;
        logic [1:0]                     dec_errors;

        ecc_apb_regs u_regs (
                .clk      (clk),
                .rst      (rst),
                .psel     (psel),
                .penable  (penable),
                .pwrite   (pwrite),
                .paddr    (paddr),
                .pwdata   (pwdata),
                .prdata   (prdata),
                .ctrl     (ctrl),
                .data_in  (data_in),
                .cw_width (cw_width),
                .noise    (noise),
                .start    (start),
                .busy     (busy)
        );

        ecc_encoder u_encoder (
                .clk      (clk),
                .rst      (rst),
                .data_in  (data_in[`ECC_MAX_INFO-1:0]),
                .cw_width (cw_width),
                .enc_word (enc_word)
        );

        ecc_decoder u_decoder (
                .clk        (clk),
                .rst        (rst),
                .dec_in     (dec_in),
                .cw_width   (cw_width),
                .dec_data   (dec_data),
                .dec_errors (dec_errors)
        );

        ecc_channel_ctrl u_ctrl (
                .clk            (clk),
                .rst            (rst),
                .start          (start),
                .ctrl           (ctrl),
                .data_in        (data_in),
                .noise          (noise),
                .enc_word       (enc_word),
                .dec_data       (dec_data),
                .dec_errors     (dec_errors),
                .dec_in         (dec_in),
                .busy           (busy),
                .data_out       (data_out),
                .operation_done (operation_done),
                .num_of_errors  (num_of_errors)
        );

endmodule

/* bench/ecc_enc_dec_tb.sv */
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_enc_dec_tb;

        localparam int RUNS    = 80;                    // per mode
        localparam int TIMEOUT = 3 * RUNS * 12 + 300;   // 4 writes, up to 3 to done, 1 after

        logic                           clk;
        logic                           rst;
        logic                           psel;
        logic                           penable;
        logic                           pwrite;
        logic [`ECC_ADDR_WIDTH-1:0]     paddr;
        logic [`ECC_AMBA_WORD-1:0]      pwdata;
        logic [`ECC_AMBA_WORD-1:0]      prdata;
        logic [`ECC_DATA_WIDTH-1:0]     data_out;
        logic                           operation_done;
        logic [1:0]                     num_of_errors;

        int             value_errs;
        int             timing_errs;
        int             cycle_count;
        logic [31:0]    last_data;   // data_out of the previous run

        ecc_enc_dec u_ecc_enc_dec (
                .clk            (clk),
                .rst            (rst),
                .psel           (psel),
                .penable        (penable),
                .pwrite         (pwrite),
                .paddr          (paddr),
                .pwdata         (pwdata),
                .prdata         (prdata),
                .data_out       (data_out),
                .operation_done (operation_done),
                .num_of_errors  (num_of_errors)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // j-th integer from 3 up that is not a power of two
        function automatic int code_of(input int j);
                int v;
                int left;
                v = 2;
                left = j + 1;
                while (left > 0) begin
                        v++;
                        if ((v & (v - 1)) != 0)
                                left--;
                end
                return v;
        endfunction

        function automatic int info_bits(input logic [1:0] w);
                return (w == 2'd0) ? 4 : (w == 2'd1) ? 11 : 26;   // 3 acts as 32 bit
        endfunction

        function automatic int code_len(input logic [1:0] w);
                return (w == 2'd0) ? 8 : (w == 2'd1) ? 16 : 32;
        endfunction

        function automatic logic [31:0] code_mask(input logic [1:0] w);
                return (code_len(w) == 32) ? '1 : (32'd1 << code_len(w)) - 32'd1;
        endfunction

        function automatic logic [31:0] model_encode(input logic [31:0] data, input logic [1:0] w);
                int k;
                int n;
                logic [31:0] cw;
                k = info_bits(w);
                n = code_len(w);
                cw = '0;
                for (int j = 0; j < k; j++)
                        cw[j] = data[j];
                for (int i = 0; i < n - k - 1; i++)
                        for (int j = 0; j < k; j++)
                                if ((code_of(j) & (1 << i)) != 0)
                                        cw[k + i] ^= data[j];
                cw[n - 1] = ^cw;   // even parity over the whole word
                return cw;
        endfunction

        function automatic void model_decode(input logic [31:0] rx, input logic [1:0] w,
                                             output logic [31:0] data, output logic [1:0] errs);
                int k;
                logic [31:0] r;
                logic [5:0] syn;
                k = info_bits(w);
                r = rx & code_mask(w);
                syn = '0;
                data = '0;
                for (int j = 0; j < k; j++)
                        data[j] = r[j];
                for (int i = 0; i < code_len(w) - k - 1; i++) begin
                        syn[i] = r[k + i];
                        for (int j = 0; j < k; j++)
                                if ((code_of(j) & (1 << i)) != 0)
                                        syn[i] ^= r[j];
                end
                if (^r) begin
                        errs = 2'd1;
                        for (int j = 0; j < k; j++)
                                if (syn == 6'(code_of(j)))
                                        data[j] = ~data[j];
                end else begin
                        errs = (syn != '0) ? 2'd2 : 2'd0;
                end
        endfunction

        // count distinct bit positions below n
        function automatic logic [31:0] flip_mask(input int n, input int count);
                int p1;
                int p2;
                p1 = $urandom % n;
                p2 = (p1 + 1 + $urandom % (n - 1)) % n;
                if (count == 0)
                        return '0;
                else if (count == 1)
                        return 32'd1 << p1;
                return (32'd1 << p1) | (32'd1 << p2);
        endfunction

        // called 1 ns after an edge, returns 1 ns after the write edge
        task automatic apb_write(input logic [19:0] addr, input logic [31:0] data);
                psel = 1'b1;
                pwrite = 1'b1;
                paddr = addr;
                pwdata = data;
                @(posedge clk);
                #1 penable = 1'b1;
                @(posedge clk);
                #1;
                psel = 1'b0;
                penable = 1'b0;
                pwrite = 1'b0;
        endtask

        task automatic apb_read(input logic [19:0] addr, output logic [31:0] data);
                psel = 1'b1;
                pwrite = 1'b0;
                paddr = addr;
                @(posedge clk);
                #1 penable = 1'b1;
                #1 data = prdata;   // access phase
                @(posedge clk);
                #1;
                psel = 1'b0;
                penable = 1'b0;
        endtask

        task automatic wait_done(output int cycles, output logic [31:0] dout,
                                 output logic [1:0] nerr);
                cycles = 0;
                while (operation_done !== 1'b1) begin
                        @(posedge clk);
                        #1 cycles++;
                        if (operation_done !== 1'b1 && data_out !== last_data) begin
                                $display("ERROR data_out: 0x%08h before done, held 0x%08h",
                                         data_out, last_data);
                                value_errs++;
                        end
                end
                dout = data_out;
                nerr = num_of_errors;
                @(posedge clk);
                #1;
                if (operation_done !== 1'b0) begin
                        $display("ERROR operation_done: 0x%0h after the pulse, expected 0x0",
                                 operation_done);
                        timing_errs++;
                end
                if (data_out !== dout) begin
                        $display("ERROR data_out: 0x%08h after done, expected 0x%08h",
                                 data_out, dout);
                        value_errs++;
                end
                last_data = dout;
        endtask

        task automatic run_op(input logic [1:0] op, input logic [1:0] w, input logic [31:0] data,
                              input logic [31:0] nz, input logic [31:0] exp_data,
                              input logic [1:0] exp_errs, input int exp_cycles);
                int cycles;
                logic [31:0] got;
                logic [1:0] errs;
                apb_write(`ECC_ADDR_DATA_IN, data);
                apb_write(`ECC_ADDR_CW_WIDTH, ($urandom & ~32'h3) | 32'(w));   // junk above bit 1
                apb_write(`ECC_ADDR_NOISE, nz);
                apb_write(`ECC_ADDR_CTRL, ($urandom & ~32'h3) | 32'(op));
                wait_done(cycles, got, errs);
                if (cycles != exp_cycles) begin
                        $display("ERROR operation_done: 0x%0h cycles, expected 0x%0h (op %0d)",
                                 cycles, exp_cycles, op);
                        timing_errs++;
                end
                if (got !== exp_data) begin
                        $display("ERROR data_out: got 0x%08h expected 0x%08h (op %0d width %0d)",
                                 got, exp_data, op, w);
                        value_errs++;
                end
                if (errs !== exp_errs) begin
                        $display("ERROR num_of_errors: got 0x%0h expected 0x%0h (op %0d width %0d)",
                                 errs, exp_errs, op, w);
                        value_errs++;
                end
        endtask

        initial begin
                cycle_count = 0;
                while (cycle_count < TIMEOUT) begin
                        @(posedge clk);
                        cycle_count++;
                end
                $display("timeout after %0d cycles, a run never finished", TIMEOUT);
                $display("=== FAIL ===");
                $finish;
        end

        initial begin
                int unsigned seed;
                int cyc;
                int nflip;
                logic [31:0] v;
                logic [31:0] rd;
                logic [31:0] nz;
                logic [31:0] exp_d;
                logic [1:0] exp_e;
                logic [1:0] w;
                seed = 32'ha5f11303;
                void'($urandom(seed));
                value_errs = 0;
                timing_errs = 0;
                last_data = '0;
                rst = 1'b0;
                psel = 1'b0;
                penable = 1'b0;
                pwrite = 1'b0;
                paddr = '0;
                pwdata = '0;
                repeat (2) @(posedge clk);
                #1 rst = 1'b1;

                if (operation_done !== 1'b0 || num_of_errors !== 2'd0) begin
                        $display("ERROR operation_done/num_of_errors: 0x%0h/0x%0h, expected 0x0",
                                 operation_done, num_of_errors);
                        value_errs++;
                end
                for (int a = 1; a < 4; a++) begin   // DATA_IN, CW_WIDTH, NOISE
                        v = $urandom;
                        apb_write(20'(4 * a), v);
                        apb_read(20'(4 * a), rd);
                        if (rd !== v) begin
                                $display("ERROR prdata: got 0x%08h expected 0x%08h at 0x%0h",
                                         rd, v, 4 * a);
                                value_errs++;
                        end
                end
                v = $urandom;
                apb_write(`ECC_ADDR_CTRL, v);
                wait_done(cyc, rd, exp_e);
                apb_read(`ECC_ADDR_CTRL, rd);
                if (rd !== v) begin
                        $display("ERROR prdata: got 0x%08h expected 0x%08h at CTRL", rd, v);
                        value_errs++;
                end
                apb_read(20'h00010 | 20'($urandom & 32'hffff0), rd);
                if (rd !== '0) begin
                        $display("ERROR prdata: got 0x%08h expected 0x00000000 unmapped", rd);
                        value_errs++;
                end

                for (int r = 0; r < RUNS; r++) begin   // encode, op 3 acts the same
                        v = $urandom;
                        w = 2'($urandom % 4);
                        run_op(($urandom % 2 == 0) ? 2'd0 : 2'd3, w, v, $urandom,
                               model_encode(v, w), 2'd0, 2);
                end
                for (int r = 0; r < RUNS; r++) begin   // decode, junk above n
                        v = $urandom;
                        w = 2'($urandom % 4);
                        nflip = $urandom % 3;
                        rd = model_encode(v, w) ^ flip_mask(code_len(w), nflip)
                             ^ ($urandom & ~code_mask(w));
                        model_decode(rd, w, exp_d, exp_e);
                        run_op(2'd1, w, rd, $urandom, exp_d, 2'(nflip), 2);
                end
                for (int r = 0; r < RUNS; r++) begin   // full channel
                        v = $urandom;
                        w = 2'($urandom % 4);
                        nflip = $urandom % 3;
                        nz = flip_mask(code_len(w), nflip) | ($urandom & ~code_mask(w));
                        model_decode(model_encode(v, w) ^ nz, w, exp_d, exp_e);
                        run_op(2'd2, w, v, nz, exp_d, 2'(nflip), 3);
                end

                $display("errors: %0d value, %0d timing", value_errs, timing_errs);
                if (value_errs == 0 && timing_errs == 0)
                        $display("=== PASS ===");
                else
                        $display("=== FAIL ===");
                $finish;
        end

endmodule

/* ecc_enc_dec.f */
+incdir+include
src/ecc_pkg.sv
src/ecc_apb_regs.sv
src/ecc_encoder.sv
src/ecc_decoder.sv
src/ecc_channel_ctrl.sv
src/ecc_enc_dec.sv
bench/ecc_enc_dec_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ECC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
        -f ecc_enc_dec.f --top-module ecc_enc_dec_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
        echo "build failed"
        exit 1
fi

./obj_dir/Vecc_enc_dec_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
        exit 1
fi
exit 0
